// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := requant_tile_tb
FILELIST := list.f
OBJDIR   := obj_dir
PASS_MSG := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only if the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// ==== design/escale_defines.svh ====
`ifndef ESCALE_DEFINES_SVH
`define ESCALE_DEFINES_SVH

////////////////////////////////////////////////////////////
// array geometry
////////////////////////////////////////////////////////////

// systolic arrays stacked in the conv core
`define SA_ROW_NUM 4
// rows per array, also rows per drained tile
`define ROW_NUM_IN_SA 16

////////////////////////////////////////////////////////////
// word widths
////////////////////////////////////////////////////////////

// one unsigned scale
`define E_WIDTH 16
// one scale set, one or two scales
`define E_SET_WIDTH 32
// host load word
`define E_WORD_WIDTH 512
// accumulator word per channel
`define ACC_WIDTH 32

// right shift applied after scaling
`define RQ_SHIFT 16

`endif

// ==== design/escale_pkg.sv ====
`default_nettype none

`include "escale_defines.svh"

package escale_pkg;

  ////////////////////////////////////////////////////////////
  // scale set word
  ////////////////////////////////////////////////////////////

  // mode 0 view, zero pad over one scale
  typedef struct packed {
    logic [`E_SET_WIDTH-`E_WIDTH-1:0] pad;
    logic [`E_WIDTH-1:0]              scale;
  } e_single_t;

  // mode 1 view, two scales side by side
  typedef struct packed {
    logic [`E_WIDTH-1:0] hi;
    logic [`E_WIDTH-1:0] lo;
  } e_pair_t;

  typedef union packed {
    e_single_t single;
    e_pair_t   pair;
  } e_set_t;

  ////////////////////////////////////////////////////////////
  // accumulator word
  ////////////////////////////////////////////////////////////

  // two signed 16 bit sums in mode 1
  typedef struct packed {
    logic signed [`ACC_WIDTH/2-1:0] hi;
    logic signed [`ACC_WIDTH/2-1:0] lo;
  } acc_pair_t;

  typedef union packed {
    logic signed [`ACC_WIDTH-1:0] single;
    acc_pair_t                    pair;
  } acc_word_t;

  // 8x8 or two weights in parallel
  typedef enum logic {
    rq_mode_8x8 = 1'b0,
    rq_mode_1x8 = 1'b1
  } rq_mode_t;

endpackage

`default_nettype wire

// ==== design/escale_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "escale_defines.svh"

module escale_regs (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    e_set,
  input  escale_pkg::rq_mode_t                    mode,
  input  logic [`E_WORD_WIDTH-1:0]                e_word,
  input  logic [7:0]                              e_reg_start,
  input  logic [7:0]                              e_reg_size,
  input  logic [5:0]                              out_sa_row_idx,
  output escale_pkg::e_set_t [`SA_ROW_NUM-1:0]    e_4_channel_sets
);

  import escale_pkg::*;

  // 64 entries, one per output row of the tile
  localparam int ENTRY_NUM = `SA_ROW_NUM * `ROW_NUM_IN_SA;
  // 32 fields of 16 bits in mode 0
  localparam int FIELDS_MODE0 = `E_WORD_WIDTH / `E_WIDTH;
  // 16 fields of 32 bits in mode 1
  localparam int FIELDS_MODE1 = `E_WORD_WIDTH / `E_SET_WIDTH;

  e_set_t e_tile [ENTRY_NUM];
  e_set_t e_word_val [ENTRY_NUM];
  logic [ENTRY_NUM-1:0] e_regs_ops;
  logic [8:0] reg_end;

  ////////////////////////////////////////////////////////////
  // write mask
  ////////////////////////////////////////////////////////////

  // last written entry, 1 based, nine bits so start + size never wraps
  assign reg_end = {1'b0, e_reg_start} + {1'b0, e_reg_size} - 9'd1;

  // entry e holds index e+1
  // anything outside 1..64 simply has no bit
  always_comb begin
    for (int e = 0; e < ENTRY_NUM; e++) begin
      e_regs_ops[e] = (e_reg_size != 8'd0) &&
                      (9'(e + 1) >= {1'b0, e_reg_start}) &&
                      (9'(e + 1) <= reg_end);
    end
  end

  ////////////////////////////////////////////////////////////
  // word placement
  ////////////////////////////////////////////////////////////

  // mode 0 word covers half the bank, start 1 or 33
  // mode 1 word covers a quarter, start 1, 17, 33 or 49
  // any other start leaves zeros in the range
  always_comb begin
    for (int e = 0; e < ENTRY_NUM; e++) begin
      e_word_val[e] = '0;
      if (mode == rq_mode_8x8) begin
        if (e_reg_start == 8'((e / FIELDS_MODE0) * FIELDS_MODE0 + 1)) begin
          // scale zero extended into the set
          e_word_val[e].single.pad = '0;
          e_word_val[e].single.scale = e_word[(e % FIELDS_MODE0) * `E_WIDTH +: `E_WIDTH];
        end
      end else begin
        if (e_reg_start == 8'((e / FIELDS_MODE1) * FIELDS_MODE1 + 1)) begin
          // hi and lo scales taken as one field
          e_word_val[e].pair = e_word[(e % FIELDS_MODE1) * `E_SET_WIDTH +: `E_SET_WIDTH];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // entry registers
  ////////////////////////////////////////////////////////////

  // reset must leave a zero scale everywhere
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < ENTRY_NUM; e++) begin
        e_tile[e] <= '0;
      end
    end else if (e_set) begin
      for (int e = 0; e < ENTRY_NUM; e++) begin
        if (e_regs_ops[e]) begin
          e_tile[e] <= e_word_val[e];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // four channel read
  ////////////////////////////////////////////////////////////

  // one entry per array for the current output row
  // row 0 means no valid sum, so zeros
  always_comb begin
    for (int a = 0; a < `SA_ROW_NUM; a++) begin
      if ((out_sa_row_idx == 6'd0) || (out_sa_row_idx > 6'(`ROW_NUM_IN_SA))) begin
        e_4_channel_sets[a] = '0;
      end else begin
        // entry index (array - 1) * 16 + row, minus one for zero base
        e_4_channel_sets[a] = e_tile[a * `ROW_NUM_IN_SA + int'(out_sa_row_idx) - 1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/requant_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "escale_defines.svh"

module requant_lane (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    in_valid,
  input  escale_pkg::rq_mode_t                    in_mode,
  input  escale_pkg::acc_word_t [`SA_ROW_NUM-1:0] in_acc,
  input  escale_pkg::e_set_t [`SA_ROW_NUM-1:0]    in_sets,
  input  logic [4:0]                              in_row,
  input  logic                                    in_last,
  input  logic                                    out_ready,
  output logic                                    in_ready,
  output logic                                    out_valid,
  output logic [`SA_ROW_NUM-1:0][15:0]            out_data,
  output logic [4:0]                              out_row,
  output logic                                    out_last
);

  import escale_pkg::*;

  // 32 bit sum times 16 bit unsigned scale
  localparam int PROD_W = `ACC_WIDTH + `E_WIDTH;

  logic advance;
  logic s1_valid;
  logic s2_valid;
  logic s3_valid;
  logic s1_last;
  logic s2_last;
  rq_mode_t s1_mode;
  rq_mode_t s2_mode;
  logic [4:0] s1_row;
  logic [4:0] s2_row;
  acc_word_t [`SA_ROW_NUM-1:0] s1_acc;
  e_set_t [`SA_ROW_NUM-1:0] s1_sets;
  logic signed [PROD_W-1:0] s2_prod_wide [`SA_ROW_NUM];
  logic signed [`ACC_WIDTH-1:0] s2_prod_hi [`SA_ROW_NUM];
  logic signed [`ACC_WIDTH-1:0] s2_prod_lo [`SA_ROW_NUM];

  // round half up, arithmetic shift, clip to int8
  function automatic logic [7:0] rq_sat(input logic signed [PROD_W-1:0] prod);
    logic signed [PROD_W-1:0] rounded;
    logic signed [PROD_W-1:0] shifted;
    rounded = prod + $signed(PROD_W'(1) << (`RQ_SHIFT - 1));
    shifted = rounded >>> `RQ_SHIFT;
    if (shifted > 127) begin
      rq_sat = 8'h7f;
    end else if (shifted < -128) begin
      rq_sat = 8'h80;
    end else begin
      rq_sat = shifted[7:0];
    end
  endfunction

  // whole pipe moves together, frozen by a held result
  assign advance = !s3_valid || out_ready;
  assign in_ready = advance;
  assign out_valid = s3_valid;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
      s1_last <= 1'b0;
      s2_last <= 1'b0;
      out_last <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      s1_last <= in_valid && in_last;
      s2_last <= s1_last;
      out_last <= s2_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // payload stages
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      // stage 1 takes the scales with the beat
      s1_mode <= in_mode;
      s1_acc <= in_acc;
      s1_sets <= in_sets;
      s1_row <= in_row;
      // stage 2 products
      s2_mode <= s1_mode;
      s2_row <= s1_row;
      for (int c = 0; c < `SA_ROW_NUM; c++) begin
        if (s1_mode == rq_mode_8x8) begin
          s2_prod_wide[c] <= s1_acc[c].single * $signed({1'b0, s1_sets[c].single.scale});
          s2_prod_hi[c] <= '0;
          s2_prod_lo[c] <= '0;
        end else begin
          s2_prod_wide[c] <= '0;
          s2_prod_hi[c] <= s1_acc[c].pair.hi * $signed({1'b0, s1_sets[c].pair.hi});
          s2_prod_lo[c] <= s1_acc[c].pair.lo * $signed({1'b0, s1_sets[c].pair.lo});
        end
      end
      // stage 3 round, saturate, pack
      out_row <= s2_row;
      for (int c = 0; c < `SA_ROW_NUM; c++) begin
        if (s2_mode == rq_mode_8x8) begin
          out_data[c] <= {8'h00, rq_sat(s2_prod_wide[c])};
        end else begin
          out_data[c] <= {rq_sat(s2_prod_hi[c]), rq_sat(s2_prod_lo[c])};
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/requant_tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "escale_defines.svh"

module requant_tile_top (
  input  logic                                    clk,
  input  logic                                    reset,
  // scale load port
  input  logic                                    e_set,
  input  escale_pkg::rq_mode_t                    mode,
  input  logic [`E_WORD_WIDTH-1:0]                e_word,
  input  logic [7:0]                              e_reg_start,
  input  logic [7:0]                              e_reg_size,
  // accumulator stream
  input  logic                                    acc_valid,
  output logic                                    acc_ready,
  input  escale_pkg::acc_word_t [`SA_ROW_NUM-1:0] acc_data,
  input  escale_pkg::rq_mode_t                    acc_mode,
  // result stream
  output logic                                    out_valid,
  input  logic                                    out_ready,
  output logic [`SA_ROW_NUM-1:0][15:0]            out_data,
  output logic [4:0]                              out_row,
  output logic                                    out_last
);

  import escale_pkg::*;

  e_set_t [`SA_ROW_NUM-1:0] e_4_channel_sets;
  logic [5:0] out_sa_row_idx;
  logic row_last;
  logic beat_accept;

  // beat moves when the lane can take it
  assign beat_accept = acc_valid && acc_ready;

  ////////////////////////////////////////////////////////////
  // scale bank
  ////////////////////////////////////////////////////////////

  // load mode from the host port, not the stream
  escale_regs escale_regs_inst (
    .clk              (clk),
    .reset            (reset),
    .e_set            (e_set),
    .mode             (mode),
    .e_word           (e_word),
    .e_reg_start      (e_reg_start),
    .e_reg_size       (e_reg_size),
    .out_sa_row_idx   (out_sa_row_idx),
    .e_4_channel_sets (e_4_channel_sets)
  );

  ////////////////////////////////////////////////////////////
  // row tracking and requant lane
  ////////////////////////////////////////////////////////////

  row_drain_sequencer row_drain_sequencer_inst (
    .clk            (clk),
    .reset          (reset),
    .beat_accept    (beat_accept),
    .out_sa_row_idx (out_sa_row_idx),
    .row_last       (row_last)
  );

  // row index is 1..16, low five bits carry it down the lane
  requant_lane requant_lane_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (acc_valid),
    .in_mode   (acc_mode),
    .in_acc    (acc_data),
    .in_sets   (e_4_channel_sets),
    .in_row    (out_sa_row_idx[4:0]),
    .in_last   (row_last),
    .out_ready (out_ready),
    .in_ready  (acc_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_row   (out_row),
    .out_last  (out_last)
  );

endmodule

`default_nettype wire

// ==== design/row_drain_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "escale_defines.svh"

module row_drain_sequencer (
  input  logic       clk,
  input  logic       reset,
  input  logic       beat_accept,
  output logic [5:0] out_sa_row_idx,
  output logic       row_last
);

  ////////////////////////////////////////////////////////////
  // output row counter
  ////////////////////////////////////////////////////////////

  // rows run 1..16 within each array
  // all four arrays drain the same row in one beat
  // so one count covers the whole tile

  logic at_last_row;

  assign at_last_row = (out_sa_row_idx == 6'(`ROW_NUM_IN_SA));

  always_ff @(posedge clk) begin
    if (reset) begin
      // first beat of a tile is row 1
      out_sa_row_idx <= 6'd1;
    end else if (beat_accept) begin
      if (at_last_row) begin
        // next tile starts over
        out_sa_row_idx <= 6'd1;
      end else begin
        out_sa_row_idx <= out_sa_row_idx + 6'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tile end flag
  ////////////////////////////////////////////////////////////

  // high while the pending beat is row 16
  // it travels down the lane with that beat
  assign row_last = at_last_row;

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/escale_pkg.sv
design/escale_regs.sv
design/row_drain_sequencer.sv
design/requant_lane.sv
design/requant_tile_top.sv
testbench/requant_tile_asserts.sv
testbench/requant_tile_tb.sv

// ==== testbench/requant_tile_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "escale_defines.svh"

module requant_tile_asserts (
  input logic                         clk,
  input logic                         reset,
  input logic                         acc_ready,
  input logic                         out_valid,
  input logic                         out_ready,
  input logic [`SA_ROW_NUM-1:0][15:0] out_data,
  input logic [4:0]                   out_row,
  input logic                         out_last,
  input logic [5:0]                   row_idx
);

  // failed checks so far
  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////
  // result stream
  ////////////////////////////////////////////////////////////

  // output stage empty right after reset
  assert property (@(posedge clk) reset |=> (!out_valid && !out_last))
    else begin
      $error("out_valid or out_last high in the cycle after reset");
      fail_count++;
    end

  // stalled result held as is
  assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_data) && $stable(out_row) && $stable(out_last)))
    else begin
      $error("stalled result changed before it was taken");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////
  // input side and row counter
  ////////////////////////////////////////////////////////////

  // a free output always frees the pipe
  assert property (@(posedge clk) disable iff (reset) out_ready |-> acc_ready)
    else begin
      $error("acc_ready low while out_ready high");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
    (row_idx >= 6'd1) && (row_idx <= 6'(`ROW_NUM_IN_SA)))
    else begin
      $error("row index outside 1..16");
      fail_count++;
    end

endmodule

bind requant_tile_top requant_tile_asserts requant_tile_asserts_inst (
  .clk       (clk),
  .reset     (reset),
  .acc_ready (acc_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .out_row   (out_row),
  .out_last  (out_last),
  .row_idx   (out_sa_row_idx)
);

`default_nettype wire

// ==== testbench/requant_tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "escale_defines.svh"

module requant_tile_tb;

  import escale_pkg::*;

  localparam int ENTRY_NUM = `SA_ROW_NUM * `ROW_NUM_IN_SA;
  // six tests of at most about 400 cycles each plus margin
  localparam int CYCLE_LIMIT = 4000;

  typedef acc_word_t [`SA_ROW_NUM-1:0] beat_t;
  typedef logic [`SA_ROW_NUM-1:0][15:0] result_t;

  logic clk;
  logic reset;
  logic e_set;
  rq_mode_t mode;
  logic [`E_WORD_WIDTH-1:0] e_word;
  logic [7:0] e_reg_start;
  logic [7:0] e_reg_size;
  logic acc_valid;
  logic acc_ready;
  beat_t acc_data;
  rq_mode_t acc_mode;
  logic out_valid;
  logic out_ready;
  result_t out_data;
  logic [4:0] out_row;
  logic out_last;

  // scale model indexed 1..64 as (array - 1) * 16 + row
  e_set_t e_model [1:ENTRY_NUM];
  // next row the sequencer will hand out
  int tb_row;
  logic [31:0] lfsr;
  int cycle_count;
  beat_t stim_q[$];

  requant_tile_top requant_tile_top_inst (
    .clk         (clk),
    .reset       (reset),
    .e_set       (e_set),
    .mode        (mode),
    .e_word      (e_word),
    .e_reg_start (e_reg_start),
    .e_reg_size  (e_reg_size),
    .acc_valid   (acc_valid),
    .acc_ready   (acc_ready),
    .acc_data    (acc_data),
    .acc_mode    (acc_mode),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .out_row     (out_row),
    .out_last    (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("** FAIL **");
    $fatal(1, "cycle limit reached");
  end

  ////////////////////////////////////////////////////////////
  // stimulus source
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [`E_WORD_WIDTH-1:0] random_word();
    logic [`E_WORD_WIDTH-1:0] w;
    for (int i = 0; i < `E_WORD_WIDTH / 32; i++) begin
      w[i*32 +: 32] = take_bits(32);
    end
    return w;
  endfunction

  // small 9 bit signed sums so only some results clip
  task automatic queue_random_beats(input int n, input rq_mode_t m);
    beat_t b;
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      for (int c = 0; c < `SA_ROW_NUM; c++) begin
        v = take_bits(9);
        if (m == rq_mode_8x8) begin
          b[c].single = {{23{v[8]}}, v[8:0]};
        end else begin
          b[c].pair.hi = {{7{v[8]}}, v[8:0]};
          v = take_bits(9);
          b[c].pair.lo = {{7{v[8]}}, v[8:0]};
        end
      end
      stim_q.push_back(b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // add half then shift arithmetically and clip to int8
  function automatic logic [7:0] requant_ref(input longint prod);
    longint scaled;
    scaled = (prod + (longint'(1) << (`RQ_SHIFT - 1))) >>> `RQ_SHIFT;
    if (scaled > 127) begin
      return 8'h7f;
    end else if (scaled < -128) begin
      return 8'h80;
    end
    return scaled[7:0];
  endfunction

  function automatic result_t model_beat(input beat_t acc, input rq_mode_t m, input int row);
    result_t res;
    e_set_t s;
    for (int c = 0; c < `SA_ROW_NUM; c++) begin
      s = e_model[c * `ROW_NUM_IN_SA + row];
      if (m == rq_mode_8x8) begin
        res[c] = {8'h00, requant_ref(longint'(acc[c].single) * longint'(s.single.scale))};
      end else begin
        res[c][15:8] = requant_ref(longint'(acc[c].pair.hi) * longint'(s.pair.hi));
        res[c][7:0] = requant_ref(longint'(acc[c].pair.lo) * longint'(s.pair.lo));
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  // any failed bound assertion ends the run
  initial begin : assertion_watch
    wait (requant_tile_top_inst.requant_tile_asserts_inst.fail_count != 0);
    fail_run("a bound assertion on the DUT failed");
  end

  task automatic compare_result(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_row(input string name, input logic [4:0] expected,
                             input logic [4:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s row: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic compare_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s last: expected %b, actual %b", name, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  // leaves every driver task at 10 ns past a rising edge
  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    for (int i = 1; i <= ENTRY_NUM; i++) begin
      e_model[i] = '0;
    end
    tb_row = 1;
  endtask

  // one strobe on the load port and the matching model update
  task automatic load_scales(input rq_mode_t m, input int start, input int size,
                             input logic [`E_WORD_WIDTH-1:0] word);
    int k;
    bit start_ok;
    e_set = 1'b1;
    mode = m;
    e_word = word;
    e_reg_start = 8'(start);
    e_reg_size = 8'(size);
    if (m == rq_mode_8x8) begin
      start_ok = (start == 1) || (start == 33);
    end else begin
      start_ok = (start == 1) || (start == 17) || (start == 33) || (start == 49);
    end
    for (int idx = start; idx < start + size; idx++) begin
      if (idx >= 1 && idx <= ENTRY_NUM) begin
        k = idx - start;
        e_model[idx] = '0;
        if (start_ok && m == rq_mode_8x8 && k < 32) begin
          e_model[idx].single.scale = word[k*16 +: 16];
        end else if (start_ok && m == rq_mode_1x8 && k < 16) begin
          e_model[idx].pair = word[k*32 +: 32];
        end
      end
    end
    @(posedge clk);
    #10;
    e_set = 1'b0;
  endtask

  // sends stim_q while the sink checks each result in order against the model
  task automatic drain(input string name, input rq_mode_t m, input bit random_ready);
    result_t exp_data_q[$];
    logic [4:0] exp_row_q[$];
    logic exp_last_q[$];
    logic [31:0] rbits;
    int sent;
    int got;
    int total;
    sent = 0;
    got = 0;
    total = stim_q.size();
    acc_mode = m;
    while (got < total) begin
      acc_valid = (sent < total);
      if (sent < total) begin
        acc_data = stim_q[sent];
      end
      rbits = random_ready ? take_bits(1) : 32'd1;
      out_ready = rbits[0];
      // let acc_ready settle on the new out_ready
      #1;
      if (out_valid && out_ready) begin
        if (exp_data_q.size() == 0) begin
          fail_run($sformatf("%s: a result came out with no beat in flight", name));
        end
        for (int c = 0; c < `SA_ROW_NUM; c++) begin
          compare_result($sformatf("%s beat %0d ch %0d", name, got, c),
                         exp_data_q[0][c], out_data[c]);
        end
        compare_row($sformatf("%s beat %0d", name, got), exp_row_q[0], out_row);
        compare_last($sformatf("%s beat %0d", name, got), exp_last_q[0], out_last);
        void'(exp_data_q.pop_front());
        void'(exp_row_q.pop_front());
        void'(exp_last_q.pop_front());
        got++;
      end
      if (acc_valid && acc_ready) begin
        exp_data_q.push_back(model_beat(stim_q[sent], m, tb_row));
        exp_row_q.push_back(5'(tb_row));
        exp_last_q.push_back(tb_row == `ROW_NUM_IN_SA);
        tb_row = (tb_row == `ROW_NUM_IN_SA) ? 1 : tb_row + 1;
        sent++;
      end
      @(posedge clk);
      #10;
    end
    acc_valid = 1'b0;
    out_ready = 1'b1;
    stim_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_mode0_drain();
    load_scales(rq_mode_8x8, 1, 32, random_word());
    load_scales(rq_mode_8x8, 33, 32, random_word());
    queue_random_beats(`ROW_NUM_IN_SA, rq_mode_8x8);
    drain("mode0_drain", rq_mode_8x8, 1'b0);
  endtask

  task automatic test_mode1_drain();
    for (int q = 0; q < 4; q++) begin
      load_scales(rq_mode_1x8, q * 16 + 1, 16, random_word());
    end
    queue_random_beats(`ROW_NUM_IN_SA, rq_mode_1x8);
    drain("mode1_drain", rq_mode_1x8, 1'b0);
  endtask

  // rows 6..16 of array 1 keep the old scales
  task automatic test_partial_load();
    load_scales(rq_mode_1x8, 1, 5, random_word());
    queue_random_beats(`ROW_NUM_IN_SA, rq_mode_1x8);
    drain("partial_load", rq_mode_1x8, 1'b0);
  endtask

  // two tiles with a random sink
  task automatic test_back_pressure();
    queue_random_beats(2 * `ROW_NUM_IN_SA, rq_mode_1x8);
    drain("back_pressure", rq_mode_1x8, 1'b1);
  endtask

  task automatic test_round_saturate();
    beat_t b;
    // scale 0xffff everywhere
    // max sum clips to 127 and min to -128 while +1 and -1 stay 1 and -1
    load_scales(rq_mode_8x8, 1, 32, {32{16'hffff}});
    load_scales(rq_mode_8x8, 33, 32, {32{16'hffff}});
    b[0].single = 32'sh7fffffff;
    b[1].single = 32'sh80000000;
    b[2].single = 32'sd1;
    b[3].single = -32'sd1;
    stim_q.push_back(b);
    drain("sat_mode0", rq_mode_8x8, 1'b0);
    // scale 1 where exact halves round up
    // 0x8000 gives 1 and 0x7fff gives 0
    // -0x8000 gives 0 and -0x8001 gives -1
    load_scales(rq_mode_8x8, 1, 32, {32{16'h0001}});
    load_scales(rq_mode_8x8, 33, 32, {32{16'h0001}});
    b[0].single = 32'sd32768;
    b[1].single = 32'sd32767;
    b[2].single = -32'sd32768;
    b[3].single = -32'sd32769;
    stim_q.push_back(b);
    // 127.5 rounds to 128 and clips
    // -127.5 gives -127 and -128.5 gives -128
    b[0].single = 32'sh007f8000;
    b[1].single = 32'sh007f7fff;
    b[2].single = 32'shff808000;
    b[3].single = 32'shff7f8000;
    stim_q.push_back(b);
    drain("round_mode0", rq_mode_8x8, 1'b0);
    // both halves at 0xffff
    for (int q = 0; q < 4; q++) begin
      load_scales(rq_mode_1x8, q * 16 + 1, 16, {16{32'hffffffff}});
    end
    b[0].pair = {16'sh7fff, 16'sh8000};
    b[1].pair = {16'sh0001, 16'shffff};
    b[2].pair = {16'sh0000, 16'sh0000};
    b[3].pair = {16'sh4000, 16'shc000};
    stim_q.push_back(b);
    drain("sat_mode1", rq_mode_1x8, 1'b0);
  endtask

  // reset clears the model too so every result is zero
  task automatic test_reset_clears();
    load_scales(rq_mode_8x8, 1, 32, random_word());
    load_scales(rq_mode_8x8, 33, 32, random_word());
    apply_reset();
    queue_random_beats(`ROW_NUM_IN_SA, rq_mode_8x8);
    drain("reset_clears", rq_mode_8x8, 1'b0);
  endtask

  initial begin : main
    reset = 1'b1;
    e_set = 1'b0;
    mode = rq_mode_8x8;
    e_word = '0;
    e_reg_start = 8'd0;
    e_reg_size = 8'd0;
    acc_valid = 1'b0;
    acc_data = '0;
    acc_mode = rq_mode_8x8;
    out_ready = 1'b1;
    lfsr = 32'h1233;
    tb_row = 1;
    apply_reset();
    test_mode0_drain();
    test_mode1_drain();
    test_partial_load();
    test_back_pressure();
    test_round_saturate();
    test_reset_clears();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
